//--- common/otterPkg.sv
package otterPkg;

    ////////////////////
    // Widths and constants
    ////////////////////

    localparam int xlen = 32;
    localparam int regAddrWidth = 5;

    // First fetch address after reset
    localparam logic [xlen-1:0] resetPc = '0;

    // addi x0,x0,0 fills IF/ID on a flush
    localparam logic [xlen-1:0] nopInstr = 32'h0000_0013;

    ////////////////////
    // Enumerations
    ////////////////////

    // Major opcodes of the supported subset, RV32I encodings
    typedef enum logic [6:0] {
        opReg    = 7'b0110011,
        opImm    = 7'b0010011,
        opLui    = 7'b0110111,
        opLoad   = 7'b0000011,
        opStore  = 7'b0100011,
        opBranch = 7'b1100011,
        opJal    = 7'b1101111
    } opcodeT;

    // ALU functions coded as {funct7[5], funct3}
    typedef enum logic [3:0] {
        aluAdd  = 4'b0000,
        aluSll  = 4'b0001,
        aluSlt  = 4'b0010,
        aluSltu = 4'b0011,
        aluXor  = 4'b0100,
        aluSrl  = 4'b0101,
        aluOr   = 4'b0110,
        aluAnd  = 4'b0111,
        aluSub  = 4'b1000,
        aluSra  = 4'b1101
    } aluOpT;

    // Register file write-back source
    typedef enum logic [1:0] {wbAlu, wbMem, wbPcPlus4} wbSelT;

    // Execute operand source
    typedef enum logic [1:0] {fwdNone, fwdMem, fwdWb} fwdSelT;

endpackage

//--- decode/registerFile.sv
module registerFile import otterPkg::*; (
    input  logic                    CLOCK,
    input  logic [regAddrWidth-1:0] rs1Addr,
    input  logic [regAddrWidth-1:0] rs2Addr,
    input  logic [regAddrWidth-1:0] wbRd,
    input  logic                    wbRegWrite,
    input  logic [xlen-1:0]         wbData,
    output logic [xlen-1:0]         rs1Data,
    output logic [xlen-1:0]         rs2Data
);

    // x0 has no storage
    logic [xlen-1:0] regs [1:31];

    always_ff @(posedge CLOCK) begin
        if (wbRegWrite && wbRd != '0) begin
            regs[wbRd] <= wbData;
        end
    end

    // Same-cycle write shows up on the read port
    function automatic logic [xlen-1:0] readPort(input logic [regAddrWidth-1:0] addr);
        if (addr == '0) begin
            return '0;
        end else if (wbRegWrite && wbRd == addr) begin
            return wbData;
        end
        return regs[addr];
    endfunction

    always_comb begin
        rs1Data = readPort(rs1Addr);
        rs2Data = readPort(rs2Addr);
    end

endmodule

//--- decode/decodeStage.sv
module decodeStage import otterPkg::*; (
    input  logic                    CLOCK,
    input  logic                    RESET,
    input  logic                    stall,
    input  logic                    flush,
    input  logic [xlen-1:0]         ifIdInstr,
    input  logic [xlen-1:0]         ifIdPc,
    input  logic [xlen-1:0]         rs1Data,
    input  logic [xlen-1:0]         rs2Data,
    output logic [regAddrWidth-1:0] rs1Addr,
    output logic [regAddrWidth-1:0] rs2Addr,
    output opcodeT                  idExOp,
    output aluOpT                   idExAluOp,
    output wbSelT                   idExWbSel,
    output logic                    idExAluSrcImm,
    output logic [xlen-1:0]         idExImm,
    output logic [xlen-1:0]         idExRs1Data,
    output logic [xlen-1:0]         idExRs2Data,
    output logic [regAddrWidth-1:0] idExRs1,
    output logic [regAddrWidth-1:0] idExRs2,
    output logic [regAddrWidth-1:0] idExRd,
    output logic                    idExRegWrite,
    output logic                    idExMemWrite,
    output logic                    idExMemRead,
    output logic [xlen-1:0]         idExPc
);

    logic [2:0] funct3;
    logic [regAddrWidth-1:0] rdAddr;

    // Immediate formats
    logic [xlen-1:0] immI;
    logic [xlen-1:0] immS;
    logic [xlen-1:0] immB;
    logic [xlen-1:0] immU;
    logic [xlen-1:0] immJ;

    // Decoded controls ahead of the ID/EX register
    opcodeT decOp;
    aluOpT decAluOp;
    wbSelT decWbSel;
    logic decSrcImm;
    logic [xlen-1:0] decImm;
    logic decRegWrite;
    logic decMemWrite;
    logic decMemRead;

    // Fixed field positions
    assign rs1Addr = ifIdInstr[19:15];
    assign rs2Addr = ifIdInstr[24:20];
    assign rdAddr = ifIdInstr[11:7];
    assign funct3 = ifIdInstr[14:12];

    ////////////////////
    // Immediate generator
    ////////////////////

    assign immI = {{20{ifIdInstr[31]}}, ifIdInstr[31:20]};
    assign immS = {{20{ifIdInstr[31]}}, ifIdInstr[31:25], ifIdInstr[11:7]};
    assign immB = {{19{ifIdInstr[31]}}, ifIdInstr[31], ifIdInstr[7],
                   ifIdInstr[30:25], ifIdInstr[11:8], 1'b0};
    assign immU = {ifIdInstr[31:12], 12'b0};
    assign immJ = {{11{ifIdInstr[31]}}, ifIdInstr[31], ifIdInstr[19:12],
                   ifIdInstr[20], ifIdInstr[30:21], 1'b0};

    ////////////////////
    // Control decoder
    ////////////////////

    always_comb begin
        // Unknown opcodes fall through as a harmless no-op
        decOp = opImm;
        decAluOp = aluAdd;
        decWbSel = wbAlu;
        decSrcImm = 1'b0;
        decImm = '0;
        decRegWrite = 1'b0;
        decMemWrite = 1'b0;
        decMemRead = 1'b0;
        case (opcodeT'(ifIdInstr[6:0]))
            opReg: begin
                decOp = opReg;
                decAluOp = aluOpT'({ifIdInstr[30], funct3});
                decRegWrite = 1'b1;
            end
            opImm: begin
                // Bit 30 only matters for the shift-right pair
                if (funct3 == 3'b101) begin
                    decAluOp = aluOpT'({ifIdInstr[30], funct3});
                end else begin
                    decAluOp = aluOpT'({1'b0, funct3});
                end
                decSrcImm = 1'b1;
                decImm = immI;
                decRegWrite = 1'b1;
            end
            opLui: begin
                // Execute zeroes operand A, so add returns the immediate
                decOp = opLui;
                decSrcImm = 1'b1;
                decImm = immU;
                decRegWrite = 1'b1;
            end
            opLoad: begin
                decOp = opLoad;
                decSrcImm = 1'b1;
                decImm = immI;
                decWbSel = wbMem;
                decRegWrite = 1'b1;
                decMemRead = 1'b1;
            end
            opStore: begin
                decOp = opStore;
                decSrcImm = 1'b1;
                decImm = immS;
                decMemWrite = 1'b1;
            end
            opBranch: begin
                // Condition carried in the ALU op: sub for BEQ, xor for BNE
                decOp = opBranch;
                decAluOp = funct3[0] ? aluXor : aluSub;
                decImm = immB;
            end
            opJal: begin
                decOp = opJal;
                decImm = immJ;
                decWbSel = wbPcPlus4;
                decRegWrite = 1'b1;
            end
            default: begin
            end
        endcase
    end

    ////////////////////
    // ID/EX register
    ////////////////////

    // Control half, bubble on stall or flush
    always_ff @(posedge CLOCK) begin
        if (RESET || stall || flush) begin
            idExOp <= opImm;
            idExAluOp <= aluAdd;
            idExWbSel <= wbAlu;
            idExRd <= '0;
            idExRegWrite <= 1'b0;
            idExMemWrite <= 1'b0;
            idExMemRead <= 1'b0;
        end else begin
            idExOp <= decOp;
            idExAluOp <= decAluOp;
            idExWbSel <= decWbSel;
            idExRd <= rdAddr;
            idExRegWrite <= decRegWrite;
            idExMemWrite <= decMemWrite;
            idExMemRead <= decMemRead;
        end
    end

    // Payload half
    always_ff @(posedge CLOCK) begin
        idExAluSrcImm <= decSrcImm;
        idExImm <= decImm;
        idExRs1Data <= rs1Data;
        idExRs2Data <= rs2Data;
        idExRs1 <= rs1Addr;
        idExRs2 <= rs2Addr;
        idExPc <= ifIdPc;
    end

endmodule

//--- execute/executeStage.sv
module executeStage import otterPkg::*; (
    input  logic                    CLOCK,
    input  logic                    RESET,
    input  opcodeT                  idExOp,
    input  aluOpT                   idExAluOp,
    input  wbSelT                   idExWbSel,
    input  logic                    idExAluSrcImm,
    input  logic [xlen-1:0]         idExImm,
    input  logic [xlen-1:0]         idExRs1Data,
    input  logic [xlen-1:0]         idExRs2Data,
    input  logic [regAddrWidth-1:0] idExRd,
    input  logic                    idExRegWrite,
    input  logic                    idExMemWrite,
    input  logic                    idExMemRead,
    input  logic [xlen-1:0]         idExPc,
    input  fwdSelT                  fwdA,
    input  fwdSelT                  fwdB,
    input  logic [xlen-1:0]         wbData,
    output logic                    branchTaken,
    output logic [xlen-1:0]         branchTarget,
    output logic [xlen-1:0]         exMemAluResult,
    output logic [xlen-1:0]         exMemStoreData,
    output logic [regAddrWidth-1:0] exMemRd,
    output logic                    exMemRegWrite,
    output logic                    exMemMemWrite,
    output logic                    exMemMemRead,
    output wbSelT                   exMemWbSel,
    output logic [xlen-1:0]         exMemPcPlus4
);

    logic [xlen-1:0] rs1Val;
    logic [xlen-1:0] rs2Val;
    logic [xlen-1:0] aluA;
    logic [xlen-1:0] aluB;
    logic [xlen-1:0] aluOut;
    logic [xlen-1:0] pcPlus4;
    logic opEqual;

    function automatic logic [xlen-1:0] pickOperand(
        input fwdSelT sel,
        input logic [xlen-1:0] regVal,
        input logic [xlen-1:0] memVal,
        input logic [xlen-1:0] wbVal
    );
        case (sel)
            fwdMem: return memVal;
            fwdWb: return wbVal;
            default: return regVal;
        endcase
    endfunction

    ////////////////////
    // Operand forwarding
    ////////////////////

    always_comb begin
        rs1Val = pickOperand(fwdA, idExRs1Data, exMemAluResult, wbData);
        rs2Val = pickOperand(fwdB, idExRs2Data, exMemAluResult, wbData);
    end

    // LUI ignores rs1 so add passes the immediate
    assign aluA = (idExOp == opLui) ? '0 : rs1Val;
    assign aluB = idExAluSrcImm ? idExImm : rs2Val;

    always_comb begin
        case (idExAluOp)
            aluAdd: aluOut = aluA + aluB;
            aluSub: aluOut = aluA - aluB;
            aluAnd: aluOut = aluA & aluB;
            aluOr: aluOut = aluA | aluB;
            aluXor: aluOut = aluA ^ aluB;
            aluSll: aluOut = aluA << aluB[4:0];
            aluSrl: aluOut = aluA >> aluB[4:0];
            aluSra: aluOut = $signed(aluA) >>> aluB[4:0];
            aluSlt: aluOut = {{(xlen-1){1'b0}}, $signed(aluA) < $signed(aluB)};
            aluSltu: aluOut = {{(xlen-1){1'b0}}, aluA < aluB};
            default: aluOut = '0;
        endcase
    end

    ////////////////////
    // Branch resolution
    ////////////////////

    assign opEqual = (rs1Val == rs2Val);
    assign branchTarget = idExPc + idExImm;
    assign pcPlus4 = idExPc + 4;

    // BEQ decodes to aluSub and BNE to aluXor
    always_comb begin
        branchTaken = 1'b0;
        if (idExOp == opJal) begin
            branchTaken = 1'b1;
        end else if (idExOp == opBranch) begin
            branchTaken = (idExAluOp == aluSub) ? opEqual : !opEqual;
        end
    end

    ////////////////////
    // EX/MEM register
    ////////////////////

    always_ff @(posedge CLOCK) begin
        if (RESET) begin
            exMemRd <= '0;
            exMemRegWrite <= 1'b0;
            exMemMemWrite <= 1'b0;
            exMemMemRead <= 1'b0;
            exMemWbSel <= wbAlu;
        end else begin
            exMemRd <= idExRd;
            exMemRegWrite <= idExRegWrite;
            exMemMemWrite <= idExMemWrite;
            exMemMemRead <= idExMemRead;
            exMemWbSel <= idExWbSel;
        end
    end

    always_ff @(posedge CLOCK) begin
        exMemAluResult <= aluOut;
        exMemStoreData <= rs2Val;
        exMemPcPlus4 <= pcPlus4;
    end

endmodule

//--- hw/fetchStage.sv
module fetchStage import otterPkg::*; (
    input  logic            CLOCK,
    input  logic            RESET,
    input  logic            stall,
    input  logic            flush,
    input  logic            branchTaken,
    input  logic [xlen-1:0] branchTarget,
    input  logic [xlen-1:0] imemData,
    output logic [xlen-1:0] imemAddr,
    output logic [xlen-1:0] ifIdInstr,
    output logic [xlen-1:0] ifIdPc
);

    logic [xlen-1:0] pc;

    // Instruction memory is read combinationally from the current PC
    assign imemAddr = pc;

    // Redirect beats the stall hold
    always_ff @(posedge CLOCK) begin
        if (RESET) begin
            pc <= resetPc;
        end else if (branchTaken) begin
            pc <= branchTarget;
        end else if (!stall) begin
            pc <= pc + 4;
        end
    end

    ////////////////////
    // IF/ID register
    ////////////////////

    always_ff @(posedge CLOCK) begin
        if (RESET || flush) begin
            ifIdInstr <= nopInstr;
        end else if (!stall) begin
            ifIdInstr <= imemData;
        end
    end

    // PC rides along with the fetched word
    always_ff @(posedge CLOCK) begin
        if (!stall) begin
            ifIdPc <= pc;
        end
    end

endmodule

//--- hw/hazardUnit.sv
module hazardUnit import otterPkg::*; (
    input  logic [regAddrWidth-1:0] rs1Addr,
    input  logic [regAddrWidth-1:0] rs2Addr,
    input  logic [regAddrWidth-1:0] idExRs1,
    input  logic [regAddrWidth-1:0] idExRs2,
    input  logic [regAddrWidth-1:0] idExRd,
    input  logic                    idExMemRead,
    input  logic [regAddrWidth-1:0] exMemRd,
    input  logic                    exMemRegWrite,
    input  logic [regAddrWidth-1:0] wbRd,
    input  logic                    wbRegWrite,
    input  logic                    branchTaken,
    output logic                    stall,
    output logic                    flush,
    output fwdSelT                  fwdA,
    output fwdSelT                  fwdB
);

    // Memory stage is younger, so it is checked first
    function automatic fwdSelT pickSource(input logic [regAddrWidth-1:0] src);
        if (src == '0) begin
            return fwdNone;
        end else if (exMemRegWrite && exMemRd == src) begin
            return fwdMem;
        end else if (wbRegWrite && wbRd == src) begin
            return fwdWb;
        end
        return fwdNone;
    endfunction

    always_comb begin
        fwdA = pickSource(idExRs1);
        fwdB = pickSource(idExRs2);
    end

    // Hold decode one cycle behind a load in execute
    // Both decode source fields compared for every format
    assign stall = idExMemRead && idExRd != '0 && (idExRd == rs1Addr || idExRd == rs2Addr);

    // Taken branch or jump kills the two younger instructions
    assign flush = branchTaken;

endmodule

//--- hw/memoryWriteback.sv
module memoryWriteback import otterPkg::*; (
    input  logic                    CLOCK,
    input  logic                    RESET,
    input  logic [xlen-1:0]         exMemAluResult,
    input  logic [xlen-1:0]         exMemStoreData,
    input  logic [regAddrWidth-1:0] exMemRd,
    input  logic                    exMemRegWrite,
    input  logic                    exMemMemWrite,
    input  logic                    exMemMemRead,
    input  wbSelT                   exMemWbSel,
    input  logic [xlen-1:0]         exMemPcPlus4,
    input  logic [xlen-1:0]         IOBUS_IN,
    output logic [xlen-1:0]         IOBUS_ADDR,
    output logic [xlen-1:0]         IOBUS_OUT,
    output logic                    IOBUS_WR,
    output logic [regAddrWidth-1:0] wbRd,
    output logic                    wbRegWrite,
    output logic [xlen-1:0]         wbData
);

    wbSelT memWbSel;
    logic [xlen-1:0] memWbAlu;
    logic [xlen-1:0] memWbLoad;
    logic [xlen-1:0] memWbPcPlus4;

    // Every data access goes straight out on the I/O bus
    assign IOBUS_ADDR = exMemAluResult;
    assign IOBUS_OUT = exMemStoreData;
    assign IOBUS_WR = exMemMemWrite;

    ////////////////////
    // MEM/WB register
    ////////////////////

    always_ff @(posedge CLOCK) begin
        if (RESET) begin
            wbRd <= '0;
            wbRegWrite <= 1'b0;
            memWbSel <= wbAlu;
        end else begin
            wbRd <= exMemRd;
            wbRegWrite <= exMemRegWrite;
            memWbSel <= exMemWbSel;
        end
    end

    always_ff @(posedge CLOCK) begin
        memWbAlu <= exMemAluResult;
        memWbPcPlus4 <= exMemPcPlus4;
        // Bus only sampled for loads
        if (exMemMemRead) begin
            memWbLoad <= IOBUS_IN;
        end
    end

    // Write-back source select
    always_comb begin
        case (memWbSel)
            wbMem: wbData = memWbLoad;
            wbPcPlus4: wbData = memWbPcPlus4;
            default: wbData = memWbAlu;
        endcase
    end

endmodule

//--- hw/otterPipeline.sv
module otterPipeline import otterPkg::*; (
    input  logic            CLOCK,
    input  logic            RESET,
    input  logic [xlen-1:0] imemData,
    input  logic [xlen-1:0] IOBUS_IN,
    output logic [xlen-1:0] imemAddr,
    output logic [xlen-1:0] IOBUS_ADDR,
    output logic [xlen-1:0] IOBUS_OUT,
    output logic            IOBUS_WR
);

    // Hazard strobes
    logic stall;
    logic flush;
    fwdSelT fwdA;
    fwdSelT fwdB;

    // IF/ID
    logic [xlen-1:0] ifIdInstr;
    logic [xlen-1:0] ifIdPc;

    // Register file read side
    logic [regAddrWidth-1:0] rs1Addr;
    logic [regAddrWidth-1:0] rs2Addr;
    logic [xlen-1:0] rs1Data;
    logic [xlen-1:0] rs2Data;

    // ID/EX
    opcodeT idExOp;
    aluOpT idExAluOp;
    wbSelT idExWbSel;
    logic idExAluSrcImm;
    logic [xlen-1:0] idExImm;
    logic [xlen-1:0] idExRs1Data;
    logic [xlen-1:0] idExRs2Data;
    logic [regAddrWidth-1:0] idExRs1;
    logic [regAddrWidth-1:0] idExRs2;
    logic [regAddrWidth-1:0] idExRd;
    logic idExRegWrite;
    logic idExMemWrite;
    logic idExMemRead;
    logic [xlen-1:0] idExPc;

    // Redirect from execute
    logic branchTaken;
    logic [xlen-1:0] branchTarget;

    // EX/MEM
    logic [xlen-1:0] exMemAluResult;
    logic [xlen-1:0] exMemStoreData;
    logic [regAddrWidth-1:0] exMemRd;
    logic exMemRegWrite;
    logic exMemMemWrite;
    logic exMemMemRead;
    wbSelT exMemWbSel;
    logic [xlen-1:0] exMemPcPlus4;

    // Write-back
    logic [regAddrWidth-1:0] wbRd;
    logic wbRegWrite;
    logic [xlen-1:0] wbData;

    ////////////////////
    // Stages
    ////////////////////

    fetchStage fetch_i (
        .CLOCK(CLOCK), .RESET(RESET), .stall(stall), .flush(flush),
        .branchTaken(branchTaken), .branchTarget(branchTarget), .imemData(imemData),
        .imemAddr(imemAddr), .ifIdInstr(ifIdInstr), .ifIdPc(ifIdPc)
    );

    decodeStage decode_i (
        .CLOCK(CLOCK), .RESET(RESET), .stall(stall), .flush(flush),
        .ifIdInstr(ifIdInstr), .ifIdPc(ifIdPc), .rs1Data(rs1Data), .rs2Data(rs2Data),
        .rs1Addr(rs1Addr), .rs2Addr(rs2Addr),
        .idExOp(idExOp), .idExAluOp(idExAluOp), .idExWbSel(idExWbSel),
        .idExAluSrcImm(idExAluSrcImm), .idExImm(idExImm),
        .idExRs1Data(idExRs1Data), .idExRs2Data(idExRs2Data),
        .idExRs1(idExRs1), .idExRs2(idExRs2), .idExRd(idExRd),
        .idExRegWrite(idExRegWrite), .idExMemWrite(idExMemWrite),
        .idExMemRead(idExMemRead), .idExPc(idExPc)
    );

    registerFile regFile_i (
        .CLOCK(CLOCK), .rs1Addr(rs1Addr), .rs2Addr(rs2Addr),
        .wbRd(wbRd), .wbRegWrite(wbRegWrite), .wbData(wbData),
        .rs1Data(rs1Data), .rs2Data(rs2Data)
    );

    hazardUnit hazard_i (
        .rs1Addr(rs1Addr), .rs2Addr(rs2Addr), .idExRs1(idExRs1), .idExRs2(idExRs2),
        .idExRd(idExRd), .idExMemRead(idExMemRead),
        .exMemRd(exMemRd), .exMemRegWrite(exMemRegWrite),
        .wbRd(wbRd), .wbRegWrite(wbRegWrite), .branchTaken(branchTaken),
        .stall(stall), .flush(flush), .fwdA(fwdA), .fwdB(fwdB)
    );

    executeStage execute_i (
        .CLOCK(CLOCK), .RESET(RESET),
        .idExOp(idExOp), .idExAluOp(idExAluOp), .idExWbSel(idExWbSel),
        .idExAluSrcImm(idExAluSrcImm), .idExImm(idExImm),
        .idExRs1Data(idExRs1Data), .idExRs2Data(idExRs2Data), .idExRd(idExRd),
        .idExRegWrite(idExRegWrite), .idExMemWrite(idExMemWrite),
        .idExMemRead(idExMemRead), .idExPc(idExPc),
        .fwdA(fwdA), .fwdB(fwdB), .wbData(wbData),
        .branchTaken(branchTaken), .branchTarget(branchTarget),
        .exMemAluResult(exMemAluResult), .exMemStoreData(exMemStoreData),
        .exMemRd(exMemRd), .exMemRegWrite(exMemRegWrite),
        .exMemMemWrite(exMemMemWrite), .exMemMemRead(exMemMemRead),
        .exMemWbSel(exMemWbSel), .exMemPcPlus4(exMemPcPlus4)
    );

    memoryWriteback memWb_i (
        .CLOCK(CLOCK), .RESET(RESET),
        .exMemAluResult(exMemAluResult), .exMemStoreData(exMemStoreData),
        .exMemRd(exMemRd), .exMemRegWrite(exMemRegWrite),
        .exMemMemWrite(exMemMemWrite), .exMemMemRead(exMemMemRead),
        .exMemWbSel(exMemWbSel), .exMemPcPlus4(exMemPcPlus4), .IOBUS_IN(IOBUS_IN),
        .IOBUS_ADDR(IOBUS_ADDR), .IOBUS_OUT(IOBUS_OUT), .IOBUS_WR(IOBUS_WR),
        .wbRd(wbRd), .wbRegWrite(wbRegWrite), .wbData(wbData)
    );

endmodule

//--- tb/otterPipelineTb.sv
module otterPipelineTb;
    timeunit 1ns;
    timeprecision 100ps;

    import otterPkg::*;

    localparam int clockPeriod = 8;
    localparam int memDepth = 256;
    // Header words ahead of the program in the data file
    localparam int progBase = 3;
    // Idle cycles after the last store, long enough to catch a stray one
    localparam int drainCycles = 8;

    logic CLOCK = 1'b0;
    logic RESET;
    logic [xlen-1:0] imemData;
    logic [xlen-1:0] IOBUS_IN;
    logic [xlen-1:0] imemAddr;
    logic [xlen-1:0] IOBUS_ADDR;
    logic [xlen-1:0] IOBUS_OUT;
    logic IOBUS_WR;

    // Header, program words, then address/data pairs
    logic [xlen-1:0] inputMem [0:memDepth-1];
    logic [xlen-1:0] romIndex;
    logic [xlen-1:0] ioBusValue;
    int progLen = 0;
    int storeCount = 0;
    int storesSeen = 0;
    int errorCount = 0;
    int watchdogCycles;
    logic fileLoaded = 1'b0;

    always #(clockPeriod / 2) CLOCK = ~CLOCK;

    otterPipeline dut_i (
        .CLOCK(CLOCK), .RESET(RESET), .imemData(imemData), .IOBUS_IN(IOBUS_IN),
        .imemAddr(imemAddr), .IOBUS_ADDR(IOBUS_ADDR), .IOBUS_OUT(IOBUS_OUT),
        .IOBUS_WR(IOBUS_WR)
    );

    ////////////////////
    // Program ROM
    ////////////////////

    // Word addressed, nops past the end of the program
    assign romIndex = imemAddr >> 2;
    assign imemData = (romIndex < progLen) ? inputMem[progBase + romIndex] : nopInstr;

    ////////////////////
    // Checks
    ////////////////////

    // Core state while reset is held
    task automatic checkResetState();
        if (IOBUS_WR !== 1'b0) begin
            errorCount++;
            $display("FAIL at %0t: IOBUS_WR expected 0 during reset, got %b", $realtime,
                     IOBUS_WR);
        end
        if (imemAddr !== resetPc) begin
            errorCount++;
            $display("FAIL at %0t: imemAddr expected %h after reset, got %h", $realtime,
                     resetPc, imemAddr);
        end
    endtask

    // Compare one bus write with the next pair from the file
    task automatic checkStore(input logic [xlen-1:0] addr, input logic [xlen-1:0] data);
        logic [xlen-1:0] expAddr;
        logic [xlen-1:0] expData;
        int pairIdx;
        if (storesSeen >= storeCount) begin
            errorCount++;
            $display("Unexpected store at %0t: address %h data %h, only %0d stores expected",
                     $realtime, addr, data, storeCount);
        end else begin
            pairIdx = progBase + progLen + 2 * storesSeen;
            expAddr = inputMem[pairIdx];
            expData = inputMem[pairIdx + 1];
            if (addr !== expAddr) begin
                errorCount++;
                $display("FAIL at %0t: store %0d address expected %h, got %h", $realtime,
                         storesSeen, expAddr, addr);
            end
            if (data !== expData) begin
                errorCount++;
                $display("FAIL at %0t: store %0d data expected %h, got %h", $realtime,
                         storesSeen, expData, data);
            end
        end
        storesSeen++;
    endtask

    // Closing line and verdict
    task automatic finishRun();
        $display("Errors: %0d, stores seen: %0d of %0d expected", errorCount, storesSeen,
                 storeCount);
        if (errorCount == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    endtask

    // Sample the bus mid-cycle, away from the clock edge
    always @(negedge CLOCK) begin
        if (RESET === 1'b0) begin
            if (IOBUS_WR === 1'b1) begin
                checkStore(IOBUS_ADDR, IOBUS_OUT);
            end else if (IOBUS_WR !== 1'b0) begin
                errorCount++;
                $display("IOBUS_WR is unknown at %0t after reset", $realtime);
            end
        end
    end

    ////////////////////
    // Main sequence
    ////////////////////

    initial begin
        RESET = 1'b1;
        IOBUS_IN = '0;
        $timeformat(-9, 1, " ns", 0);
        $readmemh("tb/programInput.txt", inputMem);
        progLen = inputMem[0];
        ioBusValue = inputMem[1];
        storeCount = inputMem[2];
        fileLoaded = 1'b1;
        if (progLen <= 0 || storeCount <= 0 ||
                progBase + progLen + 2 * storeCount > memDepth) begin
            errorCount++;
            $display("Data file tb/programInput.txt is missing or has a bad header");
            finishRun();
        end else begin
            // Two reset cycles, state checked after each
            @(posedge CLOCK);
            IOBUS_IN <= ioBusValue;
            @(negedge CLOCK);
            checkResetState();
            @(posedge CLOCK);
            RESET <= 1'b0;
            @(negedge CLOCK);
            checkResetState();
            wait (storesSeen >= storeCount);
            repeat (drainCycles) @(posedge CLOCK);
            finishRun();
        end
    end

    // Watchdog scaled from program length
    initial begin
        wait (fileLoaded);
        watchdogCycles = (progLen + 40) * 4;
        #(watchdogCycles * clockPeriod);
        errorCount++;
        $display("Timeout after %0d cycles: the expected stores did not all occur (%0d of %0d)",
                 watchdogCycles, storesSeen, storeCount);
        finishRun();
    end

endmodule

//--- tb/programInput.txt
// Header: program length, IOBUS_IN value, expected store count
// Then program words four per line, then one store address and data pair per line
00000034 1234ABCD 00000016
// x1=5, x2=-3, register-register ops each followed by a store
00500093 FFD00113 002081B3 10302023
40208233 10402223 0020F2B3 10502423
0020E333 10602623 0020C3B3 10702823
00112433 10802A23 001134B3 10902C23
00109533 10A02E23 001155B3 12B02023
40115633 12C02223
// Register-immediate ops and LUI
0F017693 12D02423 1000E713 12E02623
FFF0C793 12F02823 FFE12813 13002A23
FFF0B893 13102C23 01C09913 13202E23
01C15993 15302023 40115A13 15402223
12345AB7 15502423
// Load then immediate use
20002B03 001B0B93 15702623
// Taken BEQ over two stores
00108663 1E102823 1E102A23
// Not-taken BNE
00109463 14102823
// JAL over two stores, link stored
00C00C6F 1E102C23 1E102E23 15802A23
// Expected stores, address then data
00000100 00000002  // add
00000104 00000008  // sub
00000108 00000005  // and
0000010C FFFFFFFD  // or
00000110 FFFFFFF8  // xor
00000114 00000001  // slt
00000118 00000000  // sltu
0000011C 000000A0  // sll
00000120 07FFFFFF  // srl
00000124 FFFFFFFF  // sra
00000128 000000F0  // andi
0000012C 00000105  // ori
00000130 FFFFFFFA  // xori
00000134 00000001  // slti
00000138 00000001  // sltiu
0000013C 50000000  // slli
00000140 0000000F  // srli
00000144 FFFFFFFE  // srai
00000148 12345000  // lui
0000014C 1234ABCE  // load plus one
00000150 00000005  // after not-taken bne
00000154 000000C4  // jal link

//--- vlog.f
common/otterPkg.sv
decode/registerFile.sv
decode/decodeStage.sv
execute/executeStage.sv
hw/fetchStage.sv
hw/hazardUnit.sv
hw/memoryWriteback.sv
hw/otterPipeline.sv
tb/otterPipelineTb.sv
